// ==== hello_pkg.sv ====
//----------------------------------------------------------
// Shared definitions for the hello world register slave
// Bus widths, register map constants and decode states
//----------------------------------------------------------
`default_nettype none

package hello_pkg;

   // Host bus fields
   typedef logic [31:0]  bus_addr_t;
   typedef logic [4:0]   axi_id_t;
   typedef logic [127:0] bus_data_t;

   // Configuration block fields
   typedef logic [31:0]  word_t;
   typedef logic [7:0]   cfg_addr_t;

   // Word lane within the host bus, from address bits [3:2]
   typedef logic [1:0]   lane_t;

   localparam int NUM_LANES = 4;

   // Register map
   localparam cfg_addr_t HELLO_OFFSET   = 8'h00;
   localparam word_t     UNMAPPED_RDATA = 32'hffff_ffff;

   // Request acceptance states
   typedef enum logic [1:0] {
      SLV_IDLE    = 2'd0,
      SLV_WR_ADDR = 2'd1,
      SLV_CYC     = 2'd2,
      SLV_RESP    = 2'd3
   } slv_state_t;

endpackage

`default_nettype wire

// ==== cfg_if.sv ====
//----------------------------------------------------------
// Register command bus between decode and the config block
// Completion and read data are also watched by the responder
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface cfg_if;

   // Single cycle command pulses, at most one at a time
   logic                 wr;
   logic                 rd;
   hello_pkg::cfg_addr_t addr;
   hello_pkg::word_t     wdata;

   // Completion pulse, rdata valid with it
   logic                 ack;
   hello_pkg::word_t     rdata;

   modport cmd  (output wr, rd, addr, wdata, input ack);

   modport regs (input wr, rd, addr, wdata, output ack, rdata);

   // Responder only looks at completions
   modport mon  (input ack, rdata);

endinterface

`default_nettype wire

// ==== rsp_if.sv ====
//----------------------------------------------------------
// Response handoff from the decoder to the response driver
// Details stay stable from start until done
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface rsp_if;

   // One cycle pulse once the register access has finished
   logic               start;
   logic               is_wr;
   hello_pkg::axi_id_t id;
   hello_pkg::lane_t   lane;

   // Host has taken the response
   logic               done;

   modport src (output start, is_wr, id, lane, input done);

   modport dst (input start, is_wr, id, lane, output done);

endinterface

`default_nettype wire

// ==== axi_cmd_decode.sv ====
//----------------------------------------------------------
// Request acceptance FSM with fixed write priority
// Issues one register command per host request
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_cmd_decode (
   input  logic                  clk,
   input  logic                  sync_rst_n,
   input  hello_pkg::axi_id_t    awid,
   input  hello_pkg::bus_addr_t  awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  hello_pkg::bus_data_t  wdata,
   input  logic                  wvalid,
   output logic                  wready,
   input  hello_pkg::axi_id_t    arid,
   input  hello_pkg::bus_addr_t  araddr,
   input  logic                  arvalid,
   output logic                  arready,
   cfg_if.cmd                    cfg,
   rsp_if.src                    rsp
);

   hello_pkg::slv_state_t                       state;
   hello_pkg::slv_state_t                       state_nxt;
   logic                                        cyc_wr;
   logic                                        did_req;
   logic                                        req_valid;
   logic                                        issue;
   hello_pkg::bus_addr_t                        wr_addr_q;
   hello_pkg::bus_addr_t                        rd_addr_q;
   hello_pkg::axi_id_t                          wr_id_q;
   hello_pkg::axi_id_t                          rd_id_q;
   hello_pkg::bus_addr_t                        mx_addr;
   hello_pkg::lane_t                            wr_lane;
   hello_pkg::word_t [hello_pkg::NUM_LANES-1:0] wr_lanes;

   //----------------------------------------------------------
   // Request capture
   //----------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if ((state == hello_pkg::SLV_IDLE) && (awvalid || arvalid))
      begin
         wr_addr_q <= awaddr;
         rd_addr_q <= araddr;
         wr_id_q   <= awid;
         rd_id_q   <= arid;
      end
   end

   // Winner of the arbitration, write always first
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         cyc_wr <= 1'b0;
      else if (state == hello_pkg::SLV_IDLE)
         cyc_wr <= awvalid;
   end

   assign mx_addr   = cyc_wr ? wr_addr_q : rd_addr_q;
   assign wr_lane   = wr_addr_q[3:2];
   assign wr_lanes  = wdata;

   // Reads need no data beat
   assign req_valid = cyc_wr ? wvalid : 1'b1;
   assign issue     = (state == hello_pkg::SLV_CYC) && req_valid && !did_req;

   //----------------------------------------------------------
   // State machine
   //----------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         hello_pkg::SLV_IDLE:
         begin
            if (awvalid)
               state_nxt = hello_pkg::SLV_WR_ADDR;
            else if (arvalid)
               state_nxt = hello_pkg::SLV_CYC;
         end
         hello_pkg::SLV_WR_ADDR:
            state_nxt = hello_pkg::SLV_CYC;
         hello_pkg::SLV_CYC:
         begin
            if (cfg.ack)
               state_nxt = hello_pkg::SLV_RESP;
         end
         hello_pkg::SLV_RESP:
         begin
            if (rsp.done)
               state_nxt = hello_pkg::SLV_IDLE;
         end
         default:
            state_nxt = hello_pkg::SLV_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         state <= hello_pkg::SLV_IDLE;
      else
         state <= state_nxt;
   end

   //----------------------------------------------------------
   // Command pulses, one per request
   //----------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         cfg.wr  <= 1'b0;
         cfg.rd  <= 1'b0;
         did_req <= 1'b0;
      end
      else
      begin
         cfg.wr <= issue && cyc_wr;
         cfg.rd <= issue && !cyc_wr;
         if (state == hello_pkg::SLV_IDLE)
            did_req <= 1'b0;
         else if (issue)
            did_req <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (issue)
      begin
         cfg.addr  <= hello_pkg::cfg_addr_t'(mx_addr);
         cfg.wdata <= wr_lanes[wr_lane];
      end
   end

   // Ready pulses and response start
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         awready   <= 1'b0;
         wready    <= 1'b0;
         arready   <= 1'b0;
         rsp.start <= 1'b0;
      end
      else
      begin
         awready   <= (state_nxt == hello_pkg::SLV_WR_ADDR);
         wready    <= (state == hello_pkg::SLV_CYC) && cfg.ack && cyc_wr;
         arready   <= (state == hello_pkg::SLV_CYC) && cfg.ack && !cyc_wr;
         rsp.start <= (state == hello_pkg::SLV_CYC) && cfg.ack;
      end
   end

   assign rsp.is_wr = cyc_wr;
   assign rsp.id    = cyc_wr ? wr_id_q : rd_id_q;
   assign rsp.lane  = mx_addr[3:2];

endmodule

`default_nettype wire

// ==== cfg_hello_regs.sv ====
//----------------------------------------------------------
// Configuration block with the hello world register
// Command stretch, acknowledge and readback mux
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cfg_hello_regs (
   input  logic clk,
   input  logic sync_rst_n,
   cfg_if.regs  cfg
);

   logic                 wr_stretch;
   logic                 rd_stretch;
   hello_pkg::cfg_addr_t addr_q;
   hello_pkg::word_t     wdata_q;
   hello_pkg::word_t     hello_q;

   // Hold each command until it has been acknowledged
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         wr_stretch <= 1'b0;
         rd_stretch <= 1'b0;
      end
      else
      begin
         wr_stretch <= cfg.wr || (wr_stretch && !cfg.ack);
         rd_stretch <= cfg.rd || (rd_stretch && !cfg.ack);
      end
   end

   always_ff @(posedge clk)
   begin
      if (cfg.wr || cfg.rd)
      begin
         addr_q  <= cfg.addr;
         wdata_q <= cfg.wdata;
      end
   end

   // Single ack, two cycles after the command
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         cfg.ack <= 1'b0;
      else
         cfg.ack <= (wr_stretch || rd_stretch) && !cfg.ack;
   end

   //----------------------------------------------------------
   // Hello world register
   //----------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         hello_q <= '0;
      else if (wr_stretch && (addr_q == hello_pkg::HELLO_OFFSET))
         hello_q <= wdata_q;
   end

   // Readback returns the register byte reversed
   always_ff @(posedge clk)
   begin
      if (addr_q == hello_pkg::HELLO_OFFSET)
         cfg.rdata <= {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};
      else
         cfg.rdata <= hello_pkg::UNMAPPED_RDATA;
   end

endmodule

`default_nettype wire

// ==== axi_resp_gen.sv ====
//----------------------------------------------------------
// Write and read response channel driver
// Read word latch and placement in its bus lane
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_resp_gen (
   input  logic                 clk,
   input  logic                 sync_rst_n,
   cfg_if.mon                   cfg,
   rsp_if.dst                   rsp,
   output hello_pkg::axi_id_t   bid,
   output logic                 bvalid,
   input  logic                 bready,
   output hello_pkg::axi_id_t   rid,
   output hello_pkg::bus_data_t rdata,
   output logic                 rvalid,
   input  logic                 rready
);

   hello_pkg::word_t                            rd_word_q;
   hello_pkg::word_t [hello_pkg::NUM_LANES-1:0] rd_lanes;

   // Capture the register data when the access completes
   always_ff @(posedge clk)
   begin
      if (cfg.ack)
         rd_word_q <= cfg.rdata;
   end

   // Word goes in its own lane, the rest reads as zero
   always_comb
   begin
      rd_lanes = '0;
      rd_lanes[rsp.lane] = rd_word_q;
   end

   assign rdata = rd_lanes;

   //----------------------------------------------------------
   // Response valids, held until the host takes them
   //----------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end
      else
      begin
         if (rsp.start && rsp.is_wr)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         if (rsp.start && !rsp.is_wr)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   assign bid      = rsp.id;
   assign rid      = rsp.id;
   assign rsp.done = (bvalid && bready) || (rvalid && rready);

endmodule

`default_nettype wire

// ==== cl_hello_world.sv ====
//----------------------------------------------------------
// Hello world register slave, top level
// Decoder, configuration block and response driver
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cl_hello_world (
   input  logic                 clk,
   input  logic                 sync_rst_n,

   // Write address and data
   input  hello_pkg::axi_id_t   awid,
   input  hello_pkg::bus_addr_t awaddr,
   input  logic                 awvalid,
   output logic                 awready,
   input  hello_pkg::bus_data_t wdata,
   input  logic                 wvalid,
   output logic                 wready,

   // Write response
   output hello_pkg::axi_id_t   bid,
   output logic                 bvalid,
   input  logic                 bready,

   // Read address and data
   input  hello_pkg::axi_id_t   arid,
   input  hello_pkg::bus_addr_t araddr,
   input  logic                 arvalid,
   output logic                 arready,
   output hello_pkg::axi_id_t   rid,
   output hello_pkg::bus_data_t rdata,
   output logic                 rvalid,
   input  logic                 rready
);

   cfg_if cfg_bus ();
   rsp_if rsp_bus ();

   axi_cmd_decode u_decode (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .awid       (awid),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wvalid     (wvalid),
      .wready     (wready),
      .arid       (arid),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .cfg        (cfg_bus.cmd),
      .rsp        (rsp_bus.src)
   );

   cfg_hello_regs u_regs (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg        (cfg_bus.regs)
   );

   axi_resp_gen u_resp (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg        (cfg_bus.mon),
      .rsp        (rsp_bus.dst),
      .bid        (bid),
      .bvalid     (bvalid),
      .bready     (bready),
      .rid        (rid),
      .rdata      (rdata),
      .rvalid     (rvalid),
      .rready     (rready)
   );

endmodule

`default_nettype wire

// ==== tb_cl_hello_world.sv ====
//----------------------------------------------------------
// Self-checking testbench for the hello world register slave
// Stimulus tasks, reference model and protocol assertions
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_cl_hello_world;

   localparam int TIMEOUT_CYCLES = 200;

   logic                 clk = 1'b0;
   logic                 sync_rst_n;
   hello_pkg::axi_id_t   awid;
   hello_pkg::bus_addr_t awaddr;
   logic                 awvalid;
   logic                 awready;
   hello_pkg::bus_data_t wdata;
   logic                 wvalid;
   logic                 wready;
   hello_pkg::axi_id_t   bid;
   logic                 bvalid;
   logic                 bready;
   hello_pkg::axi_id_t   arid;
   hello_pkg::bus_addr_t araddr;
   logic                 arvalid;
   logic                 arready;
   hello_pkg::axi_id_t   rid;
   hello_pkg::bus_data_t rdata;
   logic                 rvalid;
   logic                 rready;

   logic [15:0]          lfsr_q;
   // Expected content of the hello world register
   hello_pkg::word_t     model_reg;

   cl_hello_world u_dut (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .awid       (awid),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wvalid     (wvalid),
      .wready     (wready),
      .bid        (bid),
      .bvalid     (bvalid),
      .bready     (bready),
      .arid       (arid),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rid        (rid),
      .rdata      (rdata),
      .rvalid     (rvalid),
      .rready     (rready)
   );

   always #2 clk = ~clk;

   //----------------------------------------------------------
   // Helpers
   //----------------------------------------------------------
   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

   function automatic string err_line(input string name, input logic [127:0] got,
                                      input logic [127:0] exp);
      return $sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp);
   endfunction

   // Inputs change 1 ns after the rising edge
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   // Fibonacci LFSR on x^16+x^14+x^13+x^11 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic hello_pkg::axi_id_t random_id();
      return hello_pkg::axi_id_t'(rand_bits(5));
   endfunction

   // Random upper bits with the register offset in the low byte
   function automatic hello_pkg::bus_addr_t random_addr(input hello_pkg::cfg_addr_t offset);
      hello_pkg::bus_addr_t a;
      a      = rand_bits(32);
      a[7:0] = offset;
      return a;
   endfunction

   function automatic hello_pkg::bus_data_t random_bus();
      hello_pkg::bus_data_t d;
      for (int l = 0; l < 4; l++)
         d[l*32 +: 32] = rand_bits(32);
      return d;
   endfunction

   function automatic hello_pkg::bus_data_t place_word(input hello_pkg::word_t w,
                                                       input hello_pkg::lane_t lane,
                                                       input hello_pkg::bus_data_t fill);
      hello_pkg::bus_data_t d;
      d               = fill;
      d[lane*32 +: 32] = w;
      return d;
   endfunction

   function automatic hello_pkg::word_t reverse_bytes(input hello_pkg::word_t w);
      hello_pkg::word_t r;
      for (int b = 0; b < 4; b++)
         r[8*b +: 8] = w[8*(3-b) +: 8];
      return r;
   endfunction

   // Offset 0x00 reads back swapped, everything else all ones
   function automatic hello_pkg::word_t expected_word(input hello_pkg::bus_addr_t a);
      if (a[7:0] == 8'h00)
         return reverse_bytes(model_reg);
      else
         return 32'hffff_ffff;
   endfunction

   //----------------------------------------------------------
   // Protocol assertions
   //----------------------------------------------------------
   a_b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      bvalid && !bready |=> bvalid && $stable(bid))
      else stop_with_failure("bvalid dropped or bid changed before bready");

   a_r_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata))
      else stop_with_failure("rvalid dropped or rid or rdata changed before rready");

   a_aw_pulse: assert property (@(posedge clk) disable iff (!sync_rst_n)
      awready |=> !awready)
      else stop_with_failure("awready stayed high for more than one cycle");

   a_w_pulse: assert property (@(posedge clk) disable iff (!sync_rst_n)
      wready |=> !wready && bvalid)
      else stop_with_failure("wready was not a single pulse followed by bvalid");

   a_ar_pulse: assert property (@(posedge clk) disable iff (!sync_rst_n)
      arready |=> !arready && rvalid)
      else stop_with_failure("arready was not a single pulse followed by rvalid");

   a_no_accept: assert property (@(posedge clk) disable iff (!sync_rst_n)
      (bvalid || rvalid) |-> !awready && !arready && !(bvalid && rvalid))
      else stop_with_failure("a request was accepted while a response was pending");

   //----------------------------------------------------------
   // One host access as a write, a read or both
   // A late write waits until the read response is pending
   //----------------------------------------------------------
   task automatic access(input logic do_wr, input logic do_rd, input logic stall,
                         input logic wr_late,
                         input hello_pkg::axi_id_t w_id, input hello_pkg::bus_addr_t w_addr,
                         input hello_pkg::word_t w_word,
                         input hello_pkg::axi_id_t r_id, input hello_pkg::bus_addr_t r_addr);
      int                   cyc;
      int                   aw_cnt;
      int                   w_cnt;
      int                   ar_cnt;
      int                   b_at;
      int                   r_at;
      logic                 aw_hs;
      logic                 w_hs;
      logic                 ar_hs;
      logic                 b_hs;
      logic                 r_hs;
      logic                 b_done;
      logic                 r_done;
      logic                 late_up;
      hello_pkg::bus_data_t exp_data;
      cyc     = 0;
      aw_cnt  = 0;
      w_cnt   = 0;
      ar_cnt  = 0;
      b_at    = TIMEOUT_CYCLES;
      r_at    = TIMEOUT_CYCLES;
      aw_hs   = 1'b0;
      w_hs    = 1'b0;
      ar_hs   = 1'b0;
      b_hs    = 1'b0;
      r_hs    = 1'b0;
      b_done  = !do_wr;
      r_done  = !do_rd;
      late_up = 1'b0;
      awid    = w_id;
      awaddr  = w_addr;
      wdata   = place_word(w_word, w_addr[3:2], random_bus());
      awvalid = do_wr && !wr_late;
      wvalid  = do_wr && !wr_late;
      arid    = r_id;
      araddr  = r_addr;
      arvalid = do_rd;
      while (!(b_done && r_done))
      begin
         step();
         cyc++;
         if (cyc > TIMEOUT_CYCLES)
            stop_with_failure("timeout waiting for a response handshake");
         // Transfers completed at the edge just passed
         // Address payload is free to change once taken
         if (aw_hs)
         begin
            awvalid = 1'b0;
            awid    = ~w_id;
            awaddr  = ~w_addr;
         end
         if (w_hs)
            wvalid = 1'b0;
         if (ar_hs)
         begin
            arvalid = 1'b0;
            arid    = ~r_id;
            araddr  = ~r_addr;
         end
         b_done = b_done || b_hs;
         r_done = r_done || r_hs;
         bready = !stall || (rand_bits(1) != 0);
         rready = !stall || (rand_bits(1) != 0);
         // Late write shows up while the read response is held back
         if (wr_late && !late_up && rvalid)
         begin
            awvalid = 1'b1;
            wvalid  = 1'b1;
            rready  = 1'b0;
            late_up = 1'b1;
         end
         if (awready)
            aw_cnt++;
         if (wready)
            w_cnt++;
         if (arready)
            ar_cnt++;
         if (bvalid && (b_at == TIMEOUT_CYCLES))
            b_at = cyc;
         if (rvalid && (r_at == TIMEOUT_CYCLES))
            r_at = cyc;
         aw_hs = awvalid && awready;
         w_hs  = wvalid && wready;
         ar_hs = arvalid && arready;
         b_hs  = bvalid && bready;
         r_hs  = rvalid && rready;
         if (b_hs)
         begin
            assert (bid === w_id) else stop_with_failure(err_line("bid", bid, w_id));
            if (w_addr[7:0] == 8'h00)
               model_reg = w_word;
         end
         if (r_hs)
         begin
            exp_data = place_word(expected_word(r_addr), r_addr[3:2], '0);
            assert (rid === r_id) else stop_with_failure(err_line("rid", rid, r_id));
            assert (rdata === exp_data)
               else stop_with_failure(err_line("rdata", rdata, exp_data));
         end
      end
      bready = 1'b0;
      rready = 1'b0;
      assert (aw_cnt == int'(do_wr))
         else stop_with_failure(err_line("awready cycles", aw_cnt, do_wr));
      assert (w_cnt == int'(do_wr))
         else stop_with_failure(err_line("wready cycles", w_cnt, do_wr));
      assert (ar_cnt == int'(do_rd))
         else stop_with_failure(err_line("arready cycles", ar_cnt, do_rd));
      if (do_wr && do_rd && !wr_late)
         assert (b_at < r_at) else stop_with_failure("rvalid rose before bvalid");
   endtask

   //----------------------------------------------------------
   // Test sequence
   //----------------------------------------------------------
   initial
   begin
      hello_pkg::axi_id_t   w_id;
      hello_pkg::axi_id_t   r_id;
      hello_pkg::bus_addr_t w_addr;
      hello_pkg::bus_addr_t r_addr;
      hello_pkg::word_t     word;
      hello_pkg::cfg_addr_t offset;
      sync_rst_n = 1'b0;
      awid       = '0;
      awaddr     = '0;
      awvalid    = 1'b0;
      wdata      = '0;
      wvalid     = 1'b0;
      bready     = 1'b0;
      arid       = '0;
      araddr     = '0;
      arvalid    = 1'b0;
      rready     = 1'b0;
      lfsr_q     = 16'd27499;
      model_reg  = '0;
      repeat (3) step();
      sync_rst_n = 1'b1;
      assert (!awready && !wready && !arready && !bvalid && !rvalid)
         else stop_with_failure("a ready or valid output is high after reset");

      // Register is zero out of reset
      r_id   = random_id();
      r_addr = random_addr(8'h00);
      access(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, '0, r_id, r_addr);

      // Write then byte reversed readback
      repeat (4)
      begin
         w_id   = random_id();
         w_addr = random_addr(8'h00);
         word   = rand_bits(32);
         access(1'b1, 1'b0, 1'b1, 1'b0, w_id, w_addr, word, '0, '0);
         r_id   = random_id();
         r_addr = random_addr(8'h00);
         access(1'b0, 1'b1, 1'b1, 1'b0, '0, '0, '0, r_id, r_addr);
      end

      // Unmapped offsets read all ones and ignore writes
      repeat (4)
      begin
         offset = hello_pkg::cfg_addr_t'(rand_bits(8));
         if (offset == 8'h00)
            offset = 8'h0c;
         w_id   = random_id();
         w_addr = random_addr(offset);
         word   = rand_bits(32);
         access(1'b1, 1'b0, 1'b1, 1'b0, w_id, w_addr, word, '0, '0);
         r_id   = random_id();
         r_addr = random_addr(offset);
         access(1'b0, 1'b1, 1'b1, 1'b0, '0, '0, '0, r_id, r_addr);
         r_id   = random_id();
         r_addr = random_addr(8'h00);
         access(1'b0, 1'b1, 1'b1, 1'b0, '0, '0, '0, r_id, r_addr);
      end

      // Write and read arrive together, write goes first
      repeat (2)
      begin
         w_id   = random_id();
         w_addr = random_addr(8'h00);
         word   = rand_bits(32);
         r_id   = random_id();
         r_addr = random_addr(8'h00);
         access(1'b1, 1'b1, 1'b1, 1'b0, w_id, w_addr, word, r_id, r_addr);
      end

      // Write waits while a read response is held back
      repeat (2)
      begin
         w_id   = random_id();
         w_addr = random_addr(8'h00);
         word   = rand_bits(32);
         r_id   = random_id();
         r_addr = random_addr(8'h00);
         access(1'b1, 1'b1, 1'b1, 1'b1, w_id, w_addr, word, r_id, r_addr);
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
hello_pkg.sv
cfg_if.sv
rsp_if.sv
axi_cmd_decode.sv
cfg_hello_regs.sv
axi_resp_gen.sv
cl_hello_world.sv
tb_cl_hello_world.sv

// ==== Bender.yml ====
package:
  name: cl_hello_world

sources:
  - hello_pkg.sv
  - cfg_if.sv
  - rsp_if.sv
  - axi_cmd_decode.sv
  - cfg_hello_regs.sv
  - axi_resp_gen.sv
  - cl_hello_world.sv
  - target: test
    files:
      - tb_cl_hello_world.sv
